//--- patch_stream.f
patch_gen_pkg.sv
patch_apb_pkg.sv
patch_lfsr.sv
frame_sequencer.sv
patch_fifo.sv
patch_monitor.sv
patch_apb_regs.sv
patch_stream_top.sv
tb_patch_stream.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_patch_stream
FILELIST  := patch_stream.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Done: no errors

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_patch_stream.sv
`timescale 1ns/100ps
module tb_patch_stream
  import patch_gen_pkg::*, patch_apb_pkg::*;
();

  localparam int CLK_PERIOD      = 10;
  localparam int FRAME_LEN       = 2 + 3 * BLOCK_LEN;
  localparam int WATCHDOG_CYCLES = 3 * FRAME_LEN + 2000 + 5000;  // Frames, overflow, margin

  logic              clk_200 = 1'b0;
  logic              rst_n;
  logic [APB_AW-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;

  int          cyc = 0;
  int          wr_edge;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          test_start;
  logic [15:0] rng = 16'd89;
  string       names [9] = '{"CTRL", "STATUS", "FRAMES", "COUNT0", "COUNT1", "COUNT2",
                             "CSUM0", "CSUM1", "CSUM2"};

  patch_stream_top uut (
    .clk_200(clk_200), .rst_n(rst_n), .paddr(paddr), .psel(psel),
    .penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
    .pready(pready), .pslverr(pslverr)
  );

  always #(CLK_PERIOD / 2) clk_200 = ~clk_200;
  always @(posedge clk_200) cyc <= cyc + 1;  // Edge number, read 1 ns after the edge

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      rng = lfsr_next(rng);
      val = (val << 1) | int'(rng[0]);
    end
  endtask

  function automatic logic is_mapped(input logic [APB_AW-1:0] addr);
    return (addr[1:0] == 2'b00) && (addr <= 8'h20);
  endfunction

  function automatic logic [APB_DW-1:0] status_word(input seq_state_e s);
    return {28'd0, (s == ERROR), s};
  endfunction

  // XOR of every patch number in one frame
  function automatic logic [PATCH_W-1:0] frame_csum();
    logic [PATCH_W-1:0] x;
    x = '0;
    for (int i = 0; i < N_PATCH; i++) x ^= PATCH_W'(i);
    return x;
  endfunction

  task automatic check_val(input string name, input logic [APB_DW-1:0] got,
                           input logic [APB_DW-1:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input string what, input logic cond);
    checks++;
    assert (cond === 1'b1) else begin
      $display("Error: %s", what);
      errors++;
    end
  endtask

  task automatic do_reset();
    rst_n = 1'b0;
    repeat (10) @(posedge clk_200);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic wait_cycle(input int c);
    while (cyc < c) begin
      @(posedge clk_200);
      #1;
    end
  endtask

  task automatic idle_random();
    int n;
    take_bits(4, n);
    repeat (n) begin
      @(posedge clk_200);
      #1;
    end
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk_200);
    #1;
    penable = 1'b1;
    @(posedge clk_200);
    #1;
    wr_edge = cyc;  // Access edge
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                          output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk_200);
    #1;
    penable = 1'b1;
    @(negedge clk_200);  // Mid access cycle
    data = prdata;
    err  = pslverr;
    check_val("PREADY", 32'(pready), 32'd1);
    @(posedge clk_200);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_expect(input string name, input logic [APB_AW-1:0] addr,
                             input logic [APB_DW-1:0] exp);
    logic [APB_DW-1:0] data;
    logic              err;
    apb_read(addr, data, err);
    check_val({name, " pslverr"}, 32'(err), 32'd0);
    check_val(name, data, exp);
  endtask

  task automatic random_read();
    int                r;
    logic [APB_AW-1:0] addr;
    logic [APB_DW-1:0] data;
    logic              err;
    take_bits(1, r);
    if (r == 1) begin
      take_bits(4, r);
      addr = APB_AW'(4 * (r % 9));
    end else begin
      take_bits(APB_AW, r);
      addr = APB_AW'(r);
    end
    apb_read(addr, data, err);
    if (is_mapped(addr)) begin
      check_val($sformatf("PSLVERR at 0x%02h", addr), 32'(err), 32'd0);
    end else begin
      check_val($sformatf("PSLVERR at 0x%02h", addr), 32'(err), 32'd1);
      check_val("PRDATA", data, '0);
    end
  endtask

  task automatic wait_state(input seq_state_e s, input int max_polls,
                            output logic [APB_DW-1:0] st);
    logic err;
    int   n;
    n = 0;
    apb_read(REG_STATUS, st, err);
    while (st[2:0] != s && n < max_polls) begin
      apb_read(REG_STATUS, st, err);
      n++;
    end
    check_true($sformatf("STATUS never reached %s", s.name()), st[2:0] == s);
  endtask

  task automatic run_poll(output int frames);
    logic [APB_DW-1:0] data;
    logic              err;
    idle_random();
    apb_read(REG_STATUS, data, err);
    check_true($sformatf("STATUS 0x%08h is not a running state", data),
               (data[2:0] inside {INTERFRAME, INTER2INTRA, INTRAFRAME}) &&
               !data[STAT_ERR_BIT]);
    idle_random();
    apb_read(REG_FRAMES, data, err);
    frames = int'(data);
    random_read();
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %s %s (%0d errors)", name,
             (errors == test_start) ? "PASS" : "FAIL", errors - test_start);
    test_start = errors;
  endtask

  initial begin
    int                r;
    int                target;
    int                stop_at;
    int                frames_seen;
    logic              err;
    logic [APB_AW-1:0] addr;
    logic [APB_DW-1:0] st;
    logic [APB_DW-1:0] exp;
    logic [PATCH_W-1:0] exp_csum;
    rst_n   = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    test_start = 0;
    do_reset();

    for (int i = 0; i < 9; i++) begin
      exp = (i == 1) ? status_word(INIT) : '0;
      read_expect(names[i], APB_AW'(4 * i), exp);
    end
    end_test("after_reset");

    take_bits(16, r);
    apb_write(REG_CTRL, {14'd0, 16'(r), 2'b10});  // Drain only, run stays low
    read_expect("CTRL", REG_CTRL, 32'h2);
    apb_write(REG_CTRL, {14'd0, 16'(r), 2'b00});
    read_expect("CTRL", REG_CTRL, 32'h0);
    for (int i = 1; i < 4; i++) begin
      exp = (i == 1) ? status_word(INIT) : '0;
      take_bits(16, r);
      apb_write(APB_AW'(4 * i), 32'(r));
      read_expect(names[i], APB_AW'(4 * i), exp);
    end
    repeat (4) begin
      take_bits(APB_AW, r);
      addr = APB_AW'(r);
      if (is_mapped(addr)) addr = addr ^ 8'h01;
      apb_read(addr, st, err);
      check_val($sformatf("PSLVERR at 0x%02h", addr), 32'(err), 32'd1);
      check_val("PRDATA", st, '0);
    end
    end_test("apb_rules");

    take_bits(1, r);
    target = 1 + r;
    apb_write(REG_CTRL, 32'h3);
    stop_at = wr_edge + target * FRAME_LEN;  // Write lands in INTER2INTRA of next frame
    frames_seen = 0;
    while (cyc < stop_at - 80) begin
      run_poll(frames_seen);
      check_true($sformatf("FRAMES %0d ran past target %0d", frames_seen, target),
                 frames_seen <= target);
    end
    check_val("FRAMES", 32'(frames_seen), 32'(target));
    wait_cycle(stop_at);
    apb_write(REG_CTRL, 32'h2);
    wait_state(INIT, 20, st);
    read_expect("FRAMES", REG_FRAMES, 32'(target + 1));
    exp_csum = '0;
    for (int f = 0; f < target; f++) exp_csum ^= frame_csum();
    for (int i = 3; i < 9; i++) begin
      exp = (i < 6) ? 32'(target * N_PATCH) : 32'(exp_csum);
      read_expect(names[i], APB_AW'(4 * i), exp);
    end
    end_test("frame_run");

    do_reset();
    apb_write(REG_CTRL, 32'h1);  // No drain, lanes fill up
    read_expect("CTRL", REG_CTRL, 32'h1);
    wait_state(ERROR, 200, st);
    check_val("STATUS", st, status_word(ERROR));
    read_expect("COUNT0", REG_COUNT0, '0);
    apb_write(REG_CTRL, 32'h0);
    wait_state(INIT, 20, st);
    check_val("STATUS", st, status_word(INIT));
    end_test("overflow");

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: run still busy after %0d cycles", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- patch_stream_top.sv
`timescale 1ns/100ps
module patch_stream_top import patch_gen_pkg::*, patch_apb_pkg::*; (
  input  logic              clk_200,
  input  logic              rst_n,
  input  logic [APB_AW-1:0] paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [APB_DW-1:0] pwdata,
  output logic [APB_DW-1:0] prdata,
  output logic              pready,
  output logic              pslverr
);

  logic               run;
  logic               drain;
  logic               load;
  logic               step;
  logic               lane_en;
  seq_state_e         state;
  seed_sel_e          seed_sel;
  logic [PATCH_W-1:0] offset;
  logic [N_CAM-1:0]   wr_req;
  logic [N_CAM-1:0]   fifo_full;
  logic [N_CAM-1:0]   fifo_empty;
  logic [N_CAM-1:0]   pop;
  logic [PATCH_W-1:0] patch_num [N_CAM];
  logic [PATCH_W-1:0] fifo_dout [N_CAM];
  logic [APB_DW-1:0]  frames;
  logic [APB_DW-1:0]  count0;
  logic [APB_DW-1:0]  count1;
  logic [APB_DW-1:0]  count2;
  logic [PATCH_W-1:0] csum0;
  logic [PATCH_W-1:0] csum1;
  logic [PATCH_W-1:0] csum2;

  patch_apb_regs u_regs (
    .clk_200(clk_200), .rst_n(rst_n), .paddr(paddr), .psel(psel),
    .penable(penable), .pwrite(pwrite), .pwdata(pwdata), .state(state),
    .frames(frames), .count0(count0), .count1(count1), .count2(count2),
    .csum0(csum0), .csum1(csum1), .csum2(csum2), .prdata(prdata),
    .pready(pready), .pslverr(pslverr), .run(run), .drain(drain)
  );

  frame_sequencer u_seq (
    .clk_200(clk_200), .rst_n(rst_n), .run(run), .fifo_full(fifo_full),
    .state(state), .load(load), .seed_sel(seed_sel), .step(step),
    .offset(offset), .lane_en(lane_en)
  );

  for (genvar g = 0; g < N_CAM; g++) begin : g_lane
    patch_lfsr u_lfsr (
      .clk_200(clk_200), .rst_n(rst_n), .en(lane_en), .load(load),
      .seed_sel(seed_sel), .step(step), .offset(offset),
      .lane_id(2'(g)),  // Lane index doubles as seed
      .patch_num(patch_num[g]), .wr_req(wr_req[g])
    );

    patch_fifo #(.DEPTH(FIFO_DEPTH_DEF)) u_fifo (
      .clk_200(clk_200), .rst_n(rst_n), .push(wr_req[g]), .din(patch_num[g]),
      .pop(pop[g]), .dout(fifo_dout[g]), .full(fifo_full[g]),
      .empty(fifo_empty[g])
    );
  end

  patch_monitor u_mon (
    .clk_200(clk_200), .rst_n(rst_n), .drain(drain), .empty(fifo_empty),
    .dout0(fifo_dout[0]), .dout1(fifo_dout[1]), .dout2(fifo_dout[2]),
    .pop(pop), .frames(frames), .count0(count0), .count1(count1),
    .count2(count2), .csum0(csum0), .csum1(csum1), .csum2(csum2)
  );

endmodule

//--- patch_apb_regs.sv
`timescale 1ns/100ps
module patch_apb_regs import patch_gen_pkg::*, patch_apb_pkg::*; (
  input  logic               clk_200,
  input  logic               rst_n,
  input  logic [APB_AW-1:0]  paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [APB_DW-1:0]  pwdata,
  input  seq_state_e         state,
  input  logic [APB_DW-1:0]  frames,
  input  logic [APB_DW-1:0]  count0,
  input  logic [APB_DW-1:0]  count1,
  input  logic [APB_DW-1:0]  count2,
  input  logic [PATCH_W-1:0] csum0,
  input  logic [PATCH_W-1:0] csum1,
  input  logic [PATCH_W-1:0] csum2,
  output logic [APB_DW-1:0]  prdata,
  output logic               pready,
  output logic               pslverr,
  output logic               run,
  output logic               drain
);

  logic access;
  logic addr_ok;

  assign access = psel && penable;
  assign pready = 1'b1;  // No wait states

  always_ff @(posedge clk_200) begin
    if (!rst_n) begin
      run   <= 1'b0;
      drain <= 1'b0;
    end else if (access && pwrite && (paddr == REG_CTRL)) begin
      run   <= pwdata[CTRL_RUN_BIT];
      drain <= pwdata[CTRL_DRAIN_BIT];
    end
  end

  always_comb begin
    prdata  = '0;
    addr_ok = 1'b1;
    case (paddr)
      REG_CTRL: begin
        prdata[CTRL_RUN_BIT]   = run;
        prdata[CTRL_DRAIN_BIT] = drain;
      end
      REG_STATUS: begin
        prdata[$bits(seq_state_e)-1:0] = state;
        prdata[STAT_ERR_BIT]           = (state == ERROR);
      end
      REG_FRAMES: prdata = frames;
      REG_COUNT0: prdata = count0;
      REG_COUNT1: prdata = count1;
      REG_COUNT2: prdata = count2;
      REG_CSUM0:  prdata[PATCH_W-1:0] = csum0;
      REG_CSUM1:  prdata[PATCH_W-1:0] = csum1;
      REG_CSUM2:  prdata[PATCH_W-1:0] = csum2;
      default:    addr_ok = 1'b0;  // Unmapped reads back zero
    endcase
  end

  assign pslverr = access && !addr_ok;

endmodule

//--- patch_monitor.sv
`timescale 1ns/100ps
module patch_monitor import patch_gen_pkg::*, patch_apb_pkg::*; (
  input  logic               clk_200,
  input  logic               rst_n,
  input  logic               drain,
  input  logic [N_CAM-1:0]   empty,
  input  logic [PATCH_W-1:0] dout0,
  input  logic [PATCH_W-1:0] dout1,
  input  logic [PATCH_W-1:0] dout2,
  output logic [N_CAM-1:0]   pop,
  output logic [APB_DW-1:0]  frames,
  output logic [APB_DW-1:0]  count0,
  output logic [APB_DW-1:0]  count1,
  output logic [APB_DW-1:0]  count2,
  output logic [PATCH_W-1:0] csum0,
  output logic [PATCH_W-1:0] csum1,
  output logic [PATCH_W-1:0] csum2
);

  logic [N_CAM-1:0]   rd_vld;
  logic [PATCH_W-1:0] dout_a  [N_CAM];
  logic [APB_DW-1:0]  count_a [N_CAM];
  logic [PATCH_W-1:0] csum_a  [N_CAM];

  assign pop       = drain ? ~empty : '0;
  assign dout_a[0] = dout0;
  assign dout_a[1] = dout1;
  assign dout_a[2] = dout2;

  always_ff @(posedge clk_200) begin
    if (!rst_n) begin
      rd_vld <= '0;
      frames <= '0;
      for (int i = 0; i < N_CAM; i++) begin
        count_a[i] <= '0;
        csum_a[i]  <= '0;
      end
    end else begin
      rd_vld <= pop;  // FIFO data lands one cycle after pop
      for (int i = 0; i < N_CAM; i++) begin
        if (rd_vld[i]) begin
          if (&dout_a[i]) begin
            if (i == 0) frames <= frames + 1'b1;  // Lane 0 marker counts the frame
          end else begin
            count_a[i] <= count_a[i] + 1'b1;
            csum_a[i]  <= csum_a[i] ^ dout_a[i];
          end
        end
      end
    end
  end

  assign count0 = count_a[0];
  assign count1 = count_a[1];
  assign count2 = count_a[2];
  assign csum0  = csum_a[0];
  assign csum1  = csum_a[1];
  assign csum2  = csum_a[2];

endmodule

//--- patch_fifo.sv
`timescale 1ns/100ps
module patch_fifo import patch_gen_pkg::*; #(
  parameter int DEPTH = FIFO_DEPTH_DEF
) (
  input  logic               clk_200,
  input  logic               rst_n,
  input  logic               push,
  input  logic [PATCH_W-1:0] din,
  input  logic               pop,
  output logic [PATCH_W-1:0] dout,
  output logic               full,
  output logic               empty
);

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  logic [PATCH_W-1:0] mem [DEPTH];
  ptr_t               wr_ptr;
  ptr_t               rd_ptr;
  cnt_t               count;
  logic               do_push;
  logic               do_pop;

  assign do_push = push && !full;  // Push into a full FIFO is lost
  assign do_pop  = pop && !empty;
  assign full    = (count == cnt_t'(DEPTH));
  assign empty   = (count == '0);

  always_ff @(posedge clk_200) begin
    if (do_push) mem[wr_ptr] <= din;
    if (do_pop) dout <= mem[rd_ptr];  // Registered read
  end

  always_ff @(posedge clk_200) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

//--- frame_sequencer.sv
`timescale 1ns/100ps
module frame_sequencer import patch_gen_pkg::*; (
  input  logic               clk_200,
  input  logic               rst_n,
  input  logic               run,
  input  logic [N_CAM-1:0]   fifo_full,
  output seq_state_e         state,
  output logic               load,
  output seed_sel_e          seed_sel,
  output logic               step,
  output logic [PATCH_W-1:0] offset,
  output logic               lane_en
);

  logic [LFSR_W-1:0] step_cnt;
  logic              block_end;
  logic              frame_end;
  logic              abort;

  assign block_end = (step_cnt == LFSR_W'(BLOCK_LEN - 1));
  assign frame_end = (offset > PATCH_W'(N_PATCH - BLOCK_LEN - 1));  // Last block covered
  assign abort     = !run || (|fifo_full);

  // Lane loads take effect on the edge leaving the current state
  always_comb begin
    load     = 1'b0;
    seed_sel = SEED_LANE;
    case (state)
      INIT: begin
        load     = run;
        seed_sel = SEED_ZERO;  // Zero plus all-ones offset gives the marker
      end
      INTER2INTRA: load = !abort;
      INTRAFRAME: begin
        load     = !abort && block_end && frame_end;
        seed_sel = SEED_ZERO;
      end
      default: ;
    endcase
  end

  assign step    = (state == INTRAFRAME) && !abort;
  assign lane_en = (state == INTERFRAME) || (state == INTRAFRAME);

  always_ff @(posedge clk_200) begin
    if (!rst_n) begin
      state    <= INIT;
      step_cnt <= '0;
      offset   <= '0;
    end else begin
      case (state)
        INIT: begin
          if (run) begin
            state  <= INTERFRAME;
            offset <= '1;
          end
        end
        INTERFRAME: state <= abort ? ERROR : INTER2INTRA;
        INTER2INTRA: begin
          if (abort) begin
            state <= ERROR;
          end else begin
            state    <= INTRAFRAME;
            offset   <= '0;
            step_cnt <= '0;
          end
        end
        INTRAFRAME: begin
          if (abort) begin
            state <= ERROR;
          end else if (block_end) begin
            step_cnt <= '0;
            if (frame_end) begin
              state  <= INTERFRAME;
              offset <= '1;
            end else begin
              offset <= offset + PATCH_W'(BLOCK_LEN);
            end
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        ERROR: if (!run) state <= INIT;
        default: state <= ERROR;
      endcase
    end
  end

endmodule

//--- patch_lfsr.sv
`timescale 1ns/100ps
module patch_lfsr import patch_gen_pkg::*; (
  input  logic               clk_200,
  input  logic               rst_n,
  input  logic               en,
  input  logic               load,
  input  seed_sel_e          seed_sel,
  input  logic               step,
  input  logic [PATCH_W-1:0] offset,
  input  logic [1:0]         lane_id,
  output logic [PATCH_W-1:0] patch_num,
  output logic               wr_req
);

  logic [LFSR_W-1:0] lfsr;
  logic              fb;

  // Taps 12, 11, 10, 4; all ones is the lockup state
  assign fb = ~(lfsr[11] ^ lfsr[10] ^ lfsr[9] ^ lfsr[3]);

  always_ff @(posedge clk_200) begin
    if (!rst_n) begin
      lfsr <= '0;
    end else if (load) begin
      lfsr <= (seed_sel == SEED_ZERO) ? '0 : LFSR_W'(lane_id);
    end else if (step) begin
      lfsr <= {lfsr[LFSR_W-2:0], fb};
    end
  end

  assign patch_num = PATCH_W'(lfsr) + offset;  // Wraps to marker under all-ones offset

  // Out-of-range numbers are dropped, the marker always passes
  assign wr_req = en && ((patch_num < PATCH_W'(N_PATCH)) || (&patch_num));

endmodule

//--- patch_apb_pkg.sv
package patch_apb_pkg;

  localparam int APB_AW = 8;
  localparam int APB_DW = 32;

  localparam int CTRL_RUN_BIT   = 0;
  localparam int CTRL_DRAIN_BIT = 1;
  localparam int STAT_ERR_BIT   = 3;

  typedef enum logic [APB_AW-1:0] {
    REG_CTRL   = 8'h00,
    REG_STATUS = 8'h04,
    REG_FRAMES = 8'h08,
    REG_COUNT0 = 8'h0C,
    REG_COUNT1 = 8'h10,
    REG_COUNT2 = 8'h14,
    REG_CSUM0  = 8'h18,
    REG_CSUM1  = 8'h1C,
    REG_CSUM2  = 8'h20
  } reg_addr_e;

endpackage

//--- patch_gen_pkg.sv
package patch_gen_pkg;

  localparam int N_CAM          = 3;
  localparam int N_PATCH        = 12000;  // Short frames for simulation
  localparam int LFSR_W         = 12;
  localparam int BLOCK_LEN      = 4095;   // Full XNOR LFSR cycle
  localparam int PATCH_W        = 14;     // All ones is the SOF marker
  localparam int FIFO_DEPTH_DEF = 16;

  typedef enum logic [2:0] {
    INIT,
    INTERFRAME,
    INTER2INTRA,
    INTRAFRAME,
    ERROR
  } seq_state_e;

  // Value taken by a lane LFSR on load
  typedef enum logic {
    SEED_LANE,
    SEED_ZERO
  } seed_sel_e;

endpackage
